// File: logic/exe_pkg.sv
//######################################################################
// Shared widths, latencies, opcodes and bus structs of the execute stage
// Latencies count cycles from the accepting edge to writeback valid
// The reservation window must cover the longest latency (the divider)
//######################################################################
`default_nettype none

package exe_pkg;

    localparam int XLEN      = 32;
    localparam int REG_W     = 5;
    localparam int SHAMT_W   = $clog2(XLEN);
    localparam int LAT_ALU   = 1;
    localparam int LAT_MUL   = 3;
    localparam int LAT_DIV   = 34;
    localparam int SB_DEPTH  = LAT_DIV;
    localparam int STEP_W    = $clog2(XLEN + 1);       // Divider step counter
    localparam int DIV_CNT_W = $clog2(LAT_DIV + 1);    // Divider busy countdown

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA,
        MUL, MULH, MULHU,
        DIV, DIVU, REM, REMU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL
    } exe_op_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MUL,
        UNIT_DIV
    } exe_unit_e;

    typedef struct packed {
        exe_op_e            op;
        logic [REG_W-1:0]   rd;
        logic [XLEN-1:0]    rs1_data;
        logic [XLEN-1:0]    rs2_data;
        logic [XLEN-1:0]    imm;
        logic               use_imm;    // Immediate replaces rs2
        logic [XLEN-1:0]    pc;
        logic               use_pc;     // PC replaces rs1
        logic               pred_taken;
        logic [XLEN-1:0]    pred_target;
    } exe_issue_t;

    typedef struct packed {
        logic               valid;
        logic [REG_W-1:0]   rd;
        logic [XLEN-1:0]    result;
    } exe_wb_t;

    typedef struct packed {
        logic               valid;
        logic               taken;
        logic [XLEN-1:0]    target;
        logic               mispredict;
    } exe_bres_t;

    // Steering of an opcode to its functional unit
    function automatic exe_unit_e exe_unit_of(exe_op_e op);
        case (op)
            MUL, MULH, MULHU:                       return UNIT_MUL;
            DIV, DIVU, REM, REMU:                   return UNIT_DIV;
            BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL:    return UNIT_BRANCH;
            default:                                return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: logic/exe_alu.sv
//######################################################################
// Single-cycle integer ALU, purely combinational
// Shift amount is taken from the low bits of operand b only
// Non-ALU opcodes give zero, the caller registers the result
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; (
    input  exe_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b_i[SHAMT_W-1:0];

    always_comb begin
        result_o = '0;
        case (op_i)
            ADD: result_o = a_i + b_i;
            SUB: result_o = a_i - b_i;
            AND: result_o = a_i & b_i;
            OR:  result_o = a_i | b_i;
            XOR: result_o = a_i ^ b_i;
            SLT: begin
                // Signed compare
                result_o = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            end
            SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
            end
            SLL: result_o = a_i << shamt;
            SRL: result_o = a_i >> shamt;
            SRA: result_o = $signed(a_i) >>> shamt;   // Sign fill
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exe_branch.sv
//######################################################################
// Branch resolver, compares rs1 with rs2 and checks the prediction
// Result is registered, bres_o is valid one cycle after start_i
// A not-taken branch resolves to pc+4, JAL is always taken
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_branch import exe_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        kill_i,
    input  logic        start_i,
    input  exe_issue_t  issue_i,
    output exe_bres_t   bres_o
);

    logic               taken;
    logic [XLEN-1:0]    target;
    logic               mispredict;

    always_comb begin
        case (issue_i.op)
            BEQ:  taken = (issue_i.rs1_data == issue_i.rs2_data);
            BNE:  taken = (issue_i.rs1_data != issue_i.rs2_data);
            BLT:  taken = ($signed(issue_i.rs1_data) < $signed(issue_i.rs2_data));
            BGE:  taken = ($signed(issue_i.rs1_data) >= $signed(issue_i.rs2_data));
            BLTU: taken = (issue_i.rs1_data < issue_i.rs2_data);
            BGEU: taken = (issue_i.rs1_data >= issue_i.rs2_data);
            JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
        target     = taken ? (issue_i.pc + issue_i.imm) : (issue_i.pc + XLEN'(4));
        // Wrong direction, or right direction with a wrong target
        mispredict = (taken != issue_i.pred_taken) ||
                     (taken && (target != issue_i.pred_target));
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            bres_o.valid <= 1'b0;
        end else begin
            bres_o.valid <= start_i;
        end
        if (start_i) begin
            bres_o.taken      <= taken;
            bres_o.target     <= target;
            bres_o.mispredict <= mispredict;
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_mul.sv
//######################################################################
// Three-stage pipelined 32x32 multiplier, one issue per cycle
// MULH is signed by signed, MULHU unsigned, no MULHSU support
// kill_i drops every operation in flight
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_mul import exe_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             kill_i,
    input  logic             start_i,
    input  exe_op_e          op_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    input  logic [REG_W-1:0] rd_i,
    output exe_wb_t          wb_o
);

    logic                    s1_valid_q;
    logic [REG_W-1:0]        s1_rd_q;
    logic                    s1_hi_q;
    logic signed [XLEN:0]    s1_a_q;       // One extra bit for sign or zero extension
    logic signed [XLEN:0]    s1_b_q;
    logic                    s2_valid_q;
    logic [REG_W-1:0]        s2_rd_q;
    logic                    s2_hi_q;
    logic [2*XLEN-1:0]       s2_prod_q;
    logic                    sext;

    assign sext = (op_i == MULH);

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            wb_o.valid <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            s2_valid_q <= s1_valid_q;
            wb_o.valid <= s2_valid_q;
        end
        // Stage 1, operand capture
        s1_rd_q   <= rd_i;
        s1_hi_q   <= (op_i != MUL);
        s1_a_q    <= {sext && a_i[XLEN-1], a_i};
        s1_b_q    <= {sext && b_i[XLEN-1], b_i};
        // Stage 2, full product in 64 bits
        s2_rd_q   <= s1_rd_q;
        s2_hi_q   <= s1_hi_q;
        s2_prod_q <= s1_a_q * s1_b_q;
        // Stage 3, half select
        wb_o.rd     <= s2_rd_q;
        wb_o.result <= s2_hi_q ? s2_prod_q[2*XLEN-1:XLEN] : s2_prod_q[XLEN-1:0];
    end

endmodule

`default_nettype wire

// File: logic/exe_div.sv
//######################################################################
// Radix-2 restoring divider, one operation at a time
// Result valid 34 cycles after start_i, start only while IDLE
// Divide by zero and signed overflow follow the RISC-V rules
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_div import exe_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             kill_i,
    input  logic             start_i,
    input  exe_op_e          op_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    input  logic [REG_W-1:0] rd_i,
    output exe_wb_t          wb_o
);

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

    div_state_e         state_q;
    logic [STEP_W-1:0]  cnt_q;
    logic [XLEN-1:0]    quo_q;     // Dividend shifts out, quotient shifts in
    logic [XLEN-1:0]    rem_q;
    logic [XLEN-1:0]    dvs_q;
    logic               q_neg_q, r_neg_q, is_rem_q, zero_q;
    logic [REG_W-1:0]   rd_q;
    logic [XLEN-1:0]    res_q;
    logic               signed_op, a_neg, b_neg, last_step;
    logic [XLEN-1:0]    a_mag, b_mag, q_fix, r_fix;
    logic [XLEN:0]      shifted, diff;

    always_comb begin
        signed_op = (op_i == DIV) || (op_i == REM);
        a_neg     = signed_op && a_i[XLEN-1];
        b_neg     = signed_op && b_i[XLEN-1];
        a_mag     = a_neg ? -a_i : a_i;
        b_mag     = b_neg ? -b_i : b_i;
        last_step = (cnt_q == STEP_W'(XLEN));
        shifted   = {rem_q, quo_q[XLEN-1]};
        diff      = shifted - {1'b0, dvs_q};
        // Min / -1 needs no special case, the magnitudes already wrap right
        q_fix     = zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
        r_fix     = r_neg_q ? -rem_q : rem_q;   // x % 0 gives x back
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: if (start_i) state_q <= DIV_RUN;
                DIV_RUN:  if (last_step) state_q <= DIV_DONE;
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DIV_IDLE && start_i) begin
            quo_q    <= a_mag;
            rem_q    <= '0;
            dvs_q    <= b_mag;
            cnt_q    <= '0;
            q_neg_q  <= a_neg ^ b_neg;
            r_neg_q  <= a_neg;
            is_rem_q <= (op_i == REM) || (op_i == REMU);
            zero_q   <= (b_i == '0);
            rd_q     <= rd_i;
        end else if (state_q == DIV_RUN) begin
            if (!last_step) begin
                quo_q <= {quo_q[XLEN-2:0], !diff[XLEN]};
                rem_q <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];   // Restore
                cnt_q <= cnt_q + 1'b1;
            end else begin
                res_q <= is_rem_q ? r_fix : q_fix;
            end
        end
    end

    assign wb_o.valid  = (state_q == DIV_DONE);
    assign wb_o.rd     = rd_q;
    assign wb_o.result = res_q;

    // Issue logic must hold divides back until the unit is free
    a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> state_q == DIV_IDLE);

endmodule

`default_nettype wire

// File: logic/exe_scoreboard.sv
//######################################################################
// Writeback slot reservations for the shared result port
// Bit k of the vector marks a writeback k+1 cycles ahead
// Only one divide may be outstanding at any time
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_scoreboard import exe_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic kill_i,
    input  logic take_alu_i,
    input  logic take_mul_i,
    input  logic take_div_i,
    output logic slot_free_alu_o,
    output logic slot_free_mul_o,
    output logic div_idle_o
);

    logic [SB_DEPTH-1:0]  resv_q;
    logic [SB_DEPTH-1:0]  resv_set;
    logic [DIV_CNT_W-1:0] div_left_q;   // Cycles until the divide's slot has passed

    always_comb begin
        resv_set              = '0;
        resv_set[LAT_ALU-1]   = take_alu_i;
        resv_set[LAT_MUL-1]   = take_mul_i;
        resv_set[LAT_DIV-1]   = take_div_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            resv_q     <= '0;
            div_left_q <= '0;
        end else begin
            resv_q <= (resv_q | resv_set) >> 1;    // Window moves one cycle on
            if (take_div_i) begin
                div_left_q <= DIV_CNT_W'(LAT_DIV);
            end else if (div_left_q != '0) begin
                div_left_q <= div_left_q - 1'b1;
            end
        end
    end

    assign slot_free_alu_o = !resv_q[LAT_ALU-1];
    assign slot_free_mul_o = !resv_q[LAT_MUL-1];
    assign div_idle_o      = (div_left_q == '0);

    // Stage must never issue into a slot that is already taken
    a_no_double_resv: assert property (@(posedge clk_i) disable iff (rst_i)
        (resv_q & resv_set) == '0);

endmodule

`default_nettype wire

// File: logic/exe_stage.sv
//######################################################################
// Execute stage top, ALU, branch, multiplier and divider
// Writeback has no back-pressure, the register file always accepts
// kill_i drops everything accepted before that edge
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        kill_i,
    input  logic        issue_valid_i,
    input  exe_issue_t  issue_i,
    output logic        issue_ready_o,
    output exe_wb_t     wb_o,
    output exe_bres_t   bres_o
);

    logic [XLEN-1:0] opa, opb, alu_res;
    exe_unit_e       unit;
    logic            is_jal, accept;
    logic            take_alu, take_mul, take_div, take_br;
    logic            slot_free_alu, slot_free_mul, div_idle;
    exe_wb_t         alu_wb_q, mul_wb, div_wb;

    assign opa    = issue_i.use_pc  ? issue_i.pc  : issue_i.rs1_data;
    assign opb    = issue_i.use_imm ? issue_i.imm : issue_i.rs2_data;
    assign unit   = exe_unit_of(issue_i.op);
    assign is_jal = (issue_i.op == JAL);

    always_comb begin
        case (unit)
            UNIT_ALU:    issue_ready_o = slot_free_alu;
            UNIT_BRANCH: issue_ready_o = !is_jal || slot_free_alu;   // JAL writes pc+4
            UNIT_MUL:    issue_ready_o = slot_free_mul;
            default:     issue_ready_o = div_idle;
        endcase
        if (kill_i) issue_ready_o = 1'b0;
    end

    assign accept   = issue_valid_i && issue_ready_o;
    assign take_alu = accept && ((unit == UNIT_ALU) || is_jal);
    assign take_br  = accept && (unit == UNIT_BRANCH);
    assign take_mul = accept && (unit == UNIT_MUL);
    assign take_div = accept && (unit == UNIT_DIV);

    exe_scoreboard u_sb (.clk_i, .rst_i, .kill_i, .take_alu_i(take_alu), .take_mul_i(take_mul),
        .take_div_i(take_div), .slot_free_alu_o(slot_free_alu),
        .slot_free_mul_o(slot_free_mul), .div_idle_o(div_idle));
    exe_alu u_alu (.op_i(issue_i.op), .a_i(opa), .b_i(opb), .result_o(alu_res));
    exe_branch u_br (.clk_i, .rst_i, .kill_i, .start_i(take_br), .issue_i, .bres_o);
    exe_mul u_mul (.clk_i, .rst_i, .kill_i, .start_i(take_mul), .op_i(issue_i.op),
        .a_i(opa), .b_i(opb), .rd_i(issue_i.rd), .wb_o(mul_wb));
    exe_div u_div (.clk_i, .rst_i, .kill_i, .start_i(take_div), .op_i(issue_i.op),
        .a_i(opa), .b_i(opb), .rd_i(issue_i.rd), .wb_o(div_wb));

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            alu_wb_q.valid <= 1'b0;
        end else begin
            alu_wb_q.valid <= take_alu;
        end
        if (take_alu) begin
            alu_wb_q.rd     <= issue_i.rd;
            alu_wb_q.result <= is_jal ? (issue_i.pc + XLEN'(4)) : alu_res;
        end
    end

    always_comb begin
        if (alu_wb_q.valid)     wb_o = alu_wb_q;
        else if (mul_wb.valid)  wb_o = mul_wb;
        else if (div_wb.valid)  wb_o = div_wb;
        else                    wb_o = '0;
    end

    // Scoreboard keeps the three result sources apart
    a_wb_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({alu_wb_q.valid, mul_wb.valid, div_wb.valid}));

endmodule

`default_nettype wire

// File: tb/exe_stage_tb.sv
//######################################################################
// Random testbench for the execute stage against a cycle-keyed model
// Outputs are sampled on the falling edge, inputs change 1 ns after rise
// Model cycle j means the interval after the j-th rising edge
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module exe_stage_tb import exe_pkg::*; ();

    localparam int N_TESTS    = 6;
    localparam int N_ISSUE    = 200;
    localparam int MAX_CYCLES = N_TESTS * N_ISSUE * 40;

    logic       clk_i, rst_i, kill_i, issue_valid_i, issue_ready_o;
    exe_issue_t issue_i;
    exe_wb_t    wb_o;
    exe_bres_t  bres_o;

    integer     seed = 57;
    int         cyc = 0;
    int         errors, checks, tests_failed;
    int         div_due;                // Last cycle the divider counts as busy
    logic       accepted;
    exe_wb_t    exp_wb[int];            // Expected writeback by due cycle
    exe_bres_t  exp_br[int];

    exe_stage uut (.clk_i, .rst_i, .kill_i, .issue_valid_i, .issue_i, .issue_ready_o,
        .wb_o, .bres_o);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles, a test did not finish", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int rand_below(int n);
        return {$random(seed)} % n;
    endfunction

    // Corner values show up often, the rest is random
    function automatic logic [XLEN-1:0] extreme_operand();
        case (rand_below(8))
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            4: return 32'h7fff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    function automatic exe_issue_t gen_instr(int test_id);
        exe_issue_t ins;
        ins.rd          = rand_below(32);
        ins.rs1_data    = $random(seed);
        ins.rs2_data    = (rand_below(4) == 0) ? ins.rs1_data : $random(seed);
        ins.imm         = $random(seed);
        ins.pc          = {$random(seed)} & 32'hffff_fffc;
        ins.use_imm     = rand_below(2);
        ins.use_pc      = rand_below(2);
        ins.pred_taken  = rand_below(2);
        ins.pred_target = rand_below(2) ? ins.pc + ins.imm : $random(seed);
        case (test_id)
            1: ins.op = exe_op_e'(int'(ADD) + rand_below(10));
            2: ins.op = exe_op_e'(int'(BEQ) + rand_below(7));
            3: ins.op = exe_op_e'(int'(MUL) + rand_below(3));
            4: ins.op = exe_op_e'(int'(DIV) + rand_below(4));
            default: ins.op = exe_op_e'(rand_below(int'(JAL) + 1));
        endcase
        if (test_id == 3 || test_id == 4) begin
            ins.use_pc   = 1'b0;
            ins.use_imm  = 1'b0;
            ins.rs1_data = extreme_operand();
            ins.rs2_data = extreme_operand();
        end
        if (test_id == 4 && rand_below(16) == 0) begin
            ins.rs1_data = 32'h8000_0000;   // Signed overflow operands
            ins.rs2_data = 32'hffff_ffff;
        end
        return ins;
    endfunction

    // Integer result per the RV32IM rules
    function automatic logic [XLEN-1:0] model_result(exe_issue_t ins);
        logic [XLEN-1:0]   a, b;
        logic [2*XLEN-1:0] prod_u, prod_s;
        int                sa, sb;
        a      = ins.use_pc  ? ins.pc  : ins.rs1_data;
        b      = ins.use_imm ? ins.imm : ins.rs2_data;
        sa     = a;
        sb     = b;
        prod_u = {32'b0, a} * {32'b0, b};
        prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        case (ins.op)
            ADD:   return a + b;
            SUB:   return a - b;
            AND:   return a & b;
            OR:    return a | b;
            XOR:   return a ^ b;
            SLT:   return (sa < sb) ? 1 : 0;
            SLTU:  return (a < b) ? 1 : 0;
            SLL:   return a << b[4:0];
            SRL:   return a >> b[4:0];
            SRA:   return sa >>> b[4:0];
            MUL:   return prod_u[31:0];
            MULH:  return prod_s[63:32];
            MULHU: return prod_u[63:32];
            DIV: begin
                if (b == 0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;   // Overflow
                return sa / sb;
            end
            DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            REM: begin
                if (b == 0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 0;
                return sa % sb;
            end
            REMU:  return (b == 0) ? a : a % b;
            default: return ins.pc + 4;    // JAL link value
        endcase
    endfunction

    function automatic exe_bres_t model_branch(exe_issue_t ins);
        exe_bres_t r;
        int        s1, s2;
        s1 = ins.rs1_data;
        s2 = ins.rs2_data;
        case (ins.op)
            BEQ:  r.taken = (ins.rs1_data == ins.rs2_data);
            BNE:  r.taken = (ins.rs1_data != ins.rs2_data);
            BLT:  r.taken = (s1 < s2);
            BGE:  r.taken = (s1 >= s2);
            BLTU: r.taken = (ins.rs1_data < ins.rs2_data);
            BGEU: r.taken = (ins.rs1_data >= ins.rs2_data);
            default: r.taken = 1'b1;
        endcase
        r.valid      = 1'b1;
        r.target     = r.taken ? ins.pc + ins.imm : ins.pc + 4;
        r.mispredict = (r.taken != ins.pred_taken) || (r.taken && r.target != ins.pred_target);
        return r;
    endfunction

    function automatic logic model_ready(exe_issue_t ins, int j);
        if (kill_i) return 1'b0;
        case (exe_unit_of(ins.op))
            UNIT_ALU:    return !exp_wb.exists(j + LAT_ALU);
            UNIT_BRANCH: return ins.op != JAL || !exp_wb.exists(j + LAT_ALU);
            UNIT_MUL:    return !exp_wb.exists(j + LAT_MUL);
            default:     return j > div_due;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
        end
    endtask

    task automatic expect_wb(input int due, input exe_issue_t ins);
        exe_wb_t w;
        w.valid  = 1'b1;
        w.rd     = ins.rd;
        w.result = model_result(ins);
        exp_wb[due] = w;
    endtask

    task automatic observe_cycle();
        int        j;
        logic      exp_rdy;
        exe_wb_t   w;
        exe_bres_t r;
        j = cyc;
        if (exp_wb.exists(j)) begin
            w = exp_wb[j];
            if (!wb_o.valid) begin
                errors++;
                $display("Writeback to rd %0d due in cycle %0d never arrived", w.rd, j);
            end else begin
                check_val("wb_o.rd", wb_o.rd, w.rd);
                check_val("wb_o.result", wb_o.result, w.result);
            end
            exp_wb.delete(j);
        end else if (wb_o.valid) begin
            errors++;
            $display("Unexpected writeback to rd %0d in cycle %0d", wb_o.rd, j);
        end
        if (!$onehot0({uut.alu_wb_q.valid, uut.mul_wb.valid, uut.div_wb.valid})) begin
            errors++;
            $display("Two writeback sources are valid in cycle %0d", j);
        end
        if (exp_br.exists(j)) begin
            r = exp_br[j];
            if (!bres_o.valid) begin
                errors++;
                $display("Branch resolution due in cycle %0d never arrived", j);
            end else begin
                check_val("bres_o.taken", bres_o.taken, r.taken);
                check_val("bres_o.target", bres_o.target, r.target);
                check_val("bres_o.mispredict", bres_o.mispredict, r.mispredict);
            end
            exp_br.delete(j);
        end else if (bres_o.valid) begin
            errors++;
            $display("Unexpected branch resolution in cycle %0d", j);
        end
        exp_rdy = model_ready(issue_i, j);
        check_val("issue_ready_o", issue_ready_o, exp_rdy);
        accepted = issue_valid_i && exp_rdy;
        if (accepted) begin
            case (exe_unit_of(issue_i.op))
                UNIT_ALU: expect_wb(j + LAT_ALU, issue_i);
                UNIT_MUL: expect_wb(j + LAT_MUL, issue_i);
                UNIT_DIV: begin
                    expect_wb(j + LAT_DIV, issue_i);
                    div_due = j + LAT_DIV;
                end
                default: begin
                    exp_br[j + 1] = model_branch(issue_i);
                    if (issue_i.op == JAL) expect_wb(j + LAT_ALU, issue_i);
                end
            endcase
        end
        if (kill_i) begin                   // Everything still in flight is dropped
            exp_wb.delete();
            exp_br.delete();
            div_due = -1;
        end
    endtask

    task automatic run_test(input int test_id, input string label);
        int done;
        int err0;
        err0     = errors;
        done     = 0;
        accepted = 1'b0;
        while (done < N_ISSUE) begin
            if (!issue_valid_i || accepted) begin   // Hold until accepted
                issue_valid_i = (test_id == 3 || test_id == 4) || (rand_below(4) != 0);
                issue_i       = gen_instr(test_id);
            end
            kill_i = (test_id == 6) && (rand_below(16) == 0);
            @(negedge clk_i);
            observe_cycle();
            if (accepted) done++;
            @(posedge clk_i);
            #1;
        end
        issue_valid_i = 1'b0;
        kill_i        = 1'b0;
        repeat (LAT_DIV + 4) begin
            @(negedge clk_i);
            observe_cycle();
            @(posedge clk_i);
            #1;
        end
        if (exp_wb.num() != 0 || exp_br.num() != 0) begin
            errors++;
            $display("Results still outstanding after the drain of test %0d", test_id);
        end
        if (errors != err0) tests_failed++;
        $display("Test %0d %s: %s, %0d errors", test_id, label,
                 (errors == err0) ? "ok" : "not ok", errors - err0);
    endtask

    initial begin
        rst_i         = 1'b1;
        kill_i        = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        errors        = 0;
        checks        = 0;
        tests_failed  = 0;
        div_due       = -1;
        accepted      = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        run_test(1, "ALU ops");
        run_test(2, "branches and JAL");
        run_test(3, "back-to-back multiplies");
        run_test(4, "divides and remainders");
        run_test(5, "mixed stream");
        run_test(6, "random kills");
        $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
                 N_TESTS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_branch.sv
logic/exe_mul.sv
logic/exe_div.sv
logic/exe_scoreboard.sv
logic/exe_stage.sv
tb/exe_stage_tb.sv
